// ==== include/tz_macros.svh ====
`ifndef TZ_MACROS_SVH
`define TZ_MACROS_SVH

// longest total_zeros code is 9 bits
`define TZ_WINDOW_BITS 9

// prefix bits seen by the chroma DC table
`define TZ_CDC_BITS 3

// prefix bits seen by the TotalCoeff 4..15 table
`define TZ_MANY_BITS 6

// request to result, in clock edges
`define TZ_LATENCY 2

`endif

// ==== design/tz_bitstream_pkg.sv ====
`include "tz_macros.svh"

package tz_bitstream_pkg;

    // index 0 is the first bit in bitstream order
    typedef logic [0:`TZ_WINDOW_BITS-1] rbsp_window_t;

    // number of nonzero coefficients in the block, 0..15
    typedef logic [3:0] total_coeff_t;

    // largest count that still uses the few-coefficients table
    localparam total_coeff_t FEW_COEFF_MAX = 4'd3;

endpackage

// ==== design/tz_result_pkg.sv ====
`include "tz_macros.svh"

package tz_result_pkg;

    // decoded TotalZeros, later reused as zerosLeft
    typedef logic [3:0] total_zeros_t;

    // bits consumed, 0..TZ_WINDOW_BITS
    typedef logic [$clog2(`TZ_WINDOW_BITS + 1)-1:0] code_len_t;

endpackage

// ==== design/tz_window_stage.sv ====
`timescale 1ns/100ps
`include "tz_macros.svh"

module tz_window_stage
    import tz_bitstream_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  logic                       chroma_dc,
    input  total_coeff_t               total_coeff,
    input  rbsp_window_t               rbsp,
    output logic                       s1_valid,
    output logic                       s1_chroma_dc,
    output total_coeff_t               s1_total_coeff,
    output logic [0:`TZ_CDC_BITS-1]    cdc_window,
    output rbsp_window_t               few_window,
    output logic [0:`TZ_MANY_BITS-1]   many_window
);

    rbsp_window_t s1_rbsp;

    // ----------------------------------------
    // request registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid       <= 1'b0;
            s1_chroma_dc   <= 1'b0;
            s1_total_coeff <= '0;
        end else begin
            s1_valid       <= in_valid;
            s1_chroma_dc   <= in_valid & chroma_dc;
            s1_total_coeff <= in_valid ? total_coeff : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_rbsp <= rbsp;
        end
    end

    // ----------------------------------------
    // window routing
    // ----------------------------------------
    // unused tables are parked on all ones so they stay quiet
    always_comb begin
        cdc_window  = '1;
        few_window  = '1;
        many_window = '1;
        if (s1_valid) begin
            if (s1_chroma_dc) begin
                cdc_window = s1_rbsp[0:`TZ_CDC_BITS-1];
            end else if (s1_total_coeff <= FEW_COEFF_MAX) begin
                few_window = s1_rbsp;
            end else begin
                many_window = s1_rbsp[0:`TZ_MANY_BITS-1];
            end
        end
    end

endmodule

// ==== design/tz_lookup_few_coeffs.sv ====
`timescale 1ns/100ps
`include "tz_macros.svh"

module tz_lookup_few_coeffs
    import tz_bitstream_pkg::*, tz_result_pkg::*;
(
    input  total_coeff_t              total_coeff,
    input  logic [0:`TZ_CDC_BITS-1]   cdc_window,
    input  rbsp_window_t              few_window,
    output total_zeros_t              cdc_zeros,
    output code_len_t                 cdc_len,
    output total_zeros_t              few_zeros,
    output code_len_t                 few_len
);

    // ----------------------------------------
    // chroma DC 2x2, TotalCoeff 1..3
    // ----------------------------------------
    always_comb begin
        case (total_coeff)
            4'd1: casez (cdc_window)
                3'b1??:  {cdc_zeros, cdc_len} = {4'd0, 4'd1};
                3'b01?:  {cdc_zeros, cdc_len} = {4'd1, 4'd2};
                3'b001:  {cdc_zeros, cdc_len} = {4'd2, 4'd3};
                default: {cdc_zeros, cdc_len} = {4'd3, 4'd3};
            endcase
            4'd2: casez (cdc_window)
                3'b1??:  {cdc_zeros, cdc_len} = {4'd0, 4'd1};
                3'b01?:  {cdc_zeros, cdc_len} = {4'd1, 4'd2};
                default: {cdc_zeros, cdc_len} = {4'd2, 4'd2};
            endcase
            4'd3: casez (cdc_window)
                3'b1??:  {cdc_zeros, cdc_len} = {4'd0, 4'd1};
                default: {cdc_zeros, cdc_len} = {4'd1, 4'd1};
            endcase
            // no code is read for zero coefficients
            default: {cdc_zeros, cdc_len} = {4'd0, 4'd0};
        endcase
    end

    // ----------------------------------------
    // 4x4 blocks, TotalCoeff 1..3
    // ----------------------------------------
    always_comb begin
        case (total_coeff)
            4'd1: casez (few_window)
                9'b1????????: {few_zeros, few_len} = {4'd0, 4'd1};
                9'b011??????: {few_zeros, few_len} = {4'd1, 4'd3};
                9'b010??????: {few_zeros, few_len} = {4'd2, 4'd3};
                9'b0011?????: {few_zeros, few_len} = {4'd3, 4'd4};
                9'b0010?????: {few_zeros, few_len} = {4'd4, 4'd4};
                9'b00011????: {few_zeros, few_len} = {4'd5, 4'd5};
                9'b00010????: {few_zeros, few_len} = {4'd6, 4'd5};
                9'b000011???: {few_zeros, few_len} = {4'd7, 4'd6};
                9'b000010???: {few_zeros, few_len} = {4'd8, 4'd6};
                9'b0000011??: {few_zeros, few_len} = {4'd9, 4'd7};
                9'b0000010??: {few_zeros, few_len} = {4'd10, 4'd7};
                9'b00000011?: {few_zeros, few_len} = {4'd11, 4'd8};
                9'b00000010?: {few_zeros, few_len} = {4'd12, 4'd8};
                9'b000000011: {few_zeros, few_len} = {4'd13, 4'd9};
                9'b000000010: {few_zeros, few_len} = {4'd14, 4'd9};
                // last bit not inspected, as in the original parser
                default:      {few_zeros, few_len} = {4'd15, 4'd9};
            endcase
            4'd2: casez (few_window)
                9'b111??????: {few_zeros, few_len} = {4'd0, 4'd3};
                9'b110??????: {few_zeros, few_len} = {4'd1, 4'd3};
                9'b101??????: {few_zeros, few_len} = {4'd2, 4'd3};
                9'b100??????: {few_zeros, few_len} = {4'd3, 4'd3};
                9'b011??????: {few_zeros, few_len} = {4'd4, 4'd3};
                9'b0101?????: {few_zeros, few_len} = {4'd5, 4'd4};
                9'b0100?????: {few_zeros, few_len} = {4'd6, 4'd4};
                9'b0011?????: {few_zeros, few_len} = {4'd7, 4'd4};
                9'b0010?????: {few_zeros, few_len} = {4'd8, 4'd4};
                9'b00011????: {few_zeros, few_len} = {4'd9, 4'd5};
                9'b00010????: {few_zeros, few_len} = {4'd10, 4'd5};
                9'b000011???: {few_zeros, few_len} = {4'd11, 4'd6};
                9'b000010???: {few_zeros, few_len} = {4'd12, 4'd6};
                9'b000001???: {few_zeros, few_len} = {4'd13, 4'd6};
                default:      {few_zeros, few_len} = {4'd14, 4'd6};
            endcase
            4'd3: casez (few_window)
                9'b111??????: {few_zeros, few_len} = {4'd1, 4'd3};
                9'b110??????: {few_zeros, few_len} = {4'd2, 4'd3};
                9'b101??????: {few_zeros, few_len} = {4'd3, 4'd3};
                9'b100??????: {few_zeros, few_len} = {4'd6, 4'd3};
                9'b011??????: {few_zeros, few_len} = {4'd7, 4'd3};
                9'b0101?????: {few_zeros, few_len} = {4'd0, 4'd4};
                9'b0100?????: {few_zeros, few_len} = {4'd4, 4'd4};
                9'b0011?????: {few_zeros, few_len} = {4'd5, 4'd4};
                9'b0010?????: {few_zeros, few_len} = {4'd8, 4'd4};
                9'b00011????: {few_zeros, few_len} = {4'd9, 4'd5};
                9'b00010????: {few_zeros, few_len} = {4'd10, 4'd5};
                9'b00001????: {few_zeros, few_len} = {4'd12, 4'd5};
                9'b000001???: {few_zeros, few_len} = {4'd11, 4'd6};
                default:      {few_zeros, few_len} = {4'd13, 4'd6};
            endcase
            default: {few_zeros, few_len} = {4'd0, 4'd0};
        endcase
    end

endmodule

// ==== design/tz_lookup_many_coeffs.sv ====
`timescale 1ns/100ps
`include "tz_macros.svh"

module tz_lookup_many_coeffs
    import tz_bitstream_pkg::*, tz_result_pkg::*;
(
    input  total_coeff_t              total_coeff,
    input  logic [0:`TZ_MANY_BITS-1]  many_window,
    output total_zeros_t              many_zeros,
    output code_len_t                 many_len
);

    // ----------------------------------------
    // 4x4 blocks, TotalCoeff 4..15
    // ----------------------------------------
    // one casez per count, first matching prefix wins
    always_comb begin
        case (total_coeff)
            4'd4: casez (many_window)
                6'b111???: {many_zeros, many_len} = {4'd1, 4'd3};
                6'b110???: {many_zeros, many_len} = {4'd4, 4'd3};
                6'b101???: {many_zeros, many_len} = {4'd5, 4'd3};
                6'b100???: {many_zeros, many_len} = {4'd6, 4'd3};
                6'b011???: {many_zeros, many_len} = {4'd8, 4'd3};
                6'b0101??: {many_zeros, many_len} = {4'd2, 4'd4};
                6'b0100??: {many_zeros, many_len} = {4'd3, 4'd4};
                6'b0011??: {many_zeros, many_len} = {4'd7, 4'd4};
                6'b0010??: {many_zeros, many_len} = {4'd9, 4'd4};
                6'b00011?: {many_zeros, many_len} = {4'd0, 4'd5};
                6'b00010?: {many_zeros, many_len} = {4'd10, 4'd5};
                6'b00001?: {many_zeros, many_len} = {4'd11, 4'd5};
                default:   {many_zeros, many_len} = {4'd12, 4'd5};
            endcase
            4'd5: casez (many_window)
                6'b111???: {many_zeros, many_len} = {4'd3, 4'd3};
                6'b110???: {many_zeros, many_len} = {4'd4, 4'd3};
                6'b101???: {many_zeros, many_len} = {4'd5, 4'd3};
                6'b100???: {many_zeros, many_len} = {4'd6, 4'd3};
                6'b011???: {many_zeros, many_len} = {4'd7, 4'd3};
                6'b0101??: {many_zeros, many_len} = {4'd0, 4'd4};
                6'b0100??: {many_zeros, many_len} = {4'd1, 4'd4};
                6'b0011??: {many_zeros, many_len} = {4'd2, 4'd4};
                6'b0010??: {many_zeros, many_len} = {4'd8, 4'd4};
                6'b0001??: {many_zeros, many_len} = {4'd10, 4'd4};
                6'b00001?: {many_zeros, many_len} = {4'd9, 4'd5};
                default:   {many_zeros, many_len} = {4'd11, 4'd5};
            endcase
            4'd6: casez (many_window)
                6'b111???: {many_zeros, many_len} = {4'd2, 4'd3};
                6'b110???: {many_zeros, many_len} = {4'd3, 4'd3};
                6'b101???: {many_zeros, many_len} = {4'd4, 4'd3};
                6'b100???: {many_zeros, many_len} = {4'd5, 4'd3};
                6'b011???: {many_zeros, many_len} = {4'd6, 4'd3};
                6'b010???: {many_zeros, many_len} = {4'd7, 4'd3};
                6'b001???: {many_zeros, many_len} = {4'd9, 4'd3};
                6'b0001??: {many_zeros, many_len} = {4'd8, 4'd4};
                6'b00001?: {many_zeros, many_len} = {4'd1, 4'd5};
                6'b000001: {many_zeros, many_len} = {4'd0, 4'd6};
                default:   {many_zeros, many_len} = {4'd10, 4'd6};
            endcase
            4'd7: casez (many_window)
                6'b11????: {many_zeros, many_len} = {4'd5, 4'd2};
                6'b101???: {many_zeros, many_len} = {4'd2, 4'd3};
                6'b100???: {many_zeros, many_len} = {4'd3, 4'd3};
                6'b011???: {many_zeros, many_len} = {4'd4, 4'd3};
                6'b010???: {many_zeros, many_len} = {4'd6, 4'd3};
                6'b001???: {many_zeros, many_len} = {4'd8, 4'd3};
                6'b0001??: {many_zeros, many_len} = {4'd7, 4'd4};
                6'b00001?: {many_zeros, many_len} = {4'd1, 4'd5};
                6'b000001: {many_zeros, many_len} = {4'd0, 4'd6};
                default:   {many_zeros, many_len} = {4'd9, 4'd6};
            endcase
            4'd8: casez (many_window)
                6'b11????: {many_zeros, many_len} = {4'd4, 4'd2};
                6'b10????: {many_zeros, many_len} = {4'd5, 4'd2};
                6'b011???: {many_zeros, many_len} = {4'd3, 4'd3};
                6'b010???: {many_zeros, many_len} = {4'd6, 4'd3};
                6'b001???: {many_zeros, many_len} = {4'd7, 4'd3};
                6'b0001??: {many_zeros, many_len} = {4'd1, 4'd4};
                6'b00001?: {many_zeros, many_len} = {4'd2, 4'd5};
                6'b000001: {many_zeros, many_len} = {4'd0, 4'd6};
                default:   {many_zeros, many_len} = {4'd8, 4'd6};
            endcase
            4'd9: casez (many_window)
                6'b11????: {many_zeros, many_len} = {4'd3, 4'd2};
                6'b10????: {many_zeros, many_len} = {4'd4, 4'd2};
                6'b01????: {many_zeros, many_len} = {4'd6, 4'd2};
                6'b001???: {many_zeros, many_len} = {4'd5, 4'd3};
                6'b0001??: {many_zeros, many_len} = {4'd2, 4'd4};
                6'b00001?: {many_zeros, many_len} = {4'd7, 4'd5};
                6'b000001: {many_zeros, many_len} = {4'd0, 4'd6};
                default:   {many_zeros, many_len} = {4'd1, 4'd6};
            endcase
            4'd10: casez (many_window)
                6'b11????: {many_zeros, many_len} = {4'd3, 4'd2};
                6'b10????: {many_zeros, many_len} = {4'd4, 4'd2};
                6'b01????: {many_zeros, many_len} = {4'd5, 4'd2};
                6'b001???: {many_zeros, many_len} = {4'd2, 4'd3};
                6'b0001??: {many_zeros, many_len} = {4'd6, 4'd4};
                6'b00001?: {many_zeros, many_len} = {4'd0, 4'd5};
                default:   {many_zeros, many_len} = {4'd1, 4'd5};
            endcase
            4'd11: casez (many_window)
                6'b1?????: {many_zeros, many_len} = {4'd4, 4'd1};
                6'b011???: {many_zeros, many_len} = {4'd5, 4'd3};
                6'b010???: {many_zeros, many_len} = {4'd3, 4'd3};
                6'b001???: {many_zeros, many_len} = {4'd2, 4'd3};
                6'b0001??: {many_zeros, many_len} = {4'd1, 4'd4};
                default:   {many_zeros, many_len} = {4'd0, 4'd4};
            endcase
            4'd12: casez (many_window)
                6'b1?????: {many_zeros, many_len} = {4'd3, 4'd1};
                6'b01????: {many_zeros, many_len} = {4'd2, 4'd2};
                6'b001???: {many_zeros, many_len} = {4'd4, 4'd3};
                6'b0001??: {many_zeros, many_len} = {4'd1, 4'd4};
                default:   {many_zeros, many_len} = {4'd0, 4'd4};
            endcase
            4'd13: casez (many_window)
                6'b1?????: {many_zeros, many_len} = {4'd2, 4'd1};
                6'b01????: {many_zeros, many_len} = {4'd3, 4'd2};
                6'b001???: {many_zeros, many_len} = {4'd1, 4'd3};
                default:   {many_zeros, many_len} = {4'd0, 4'd3};
            endcase
            4'd14: casez (many_window)
                6'b1?????: {many_zeros, many_len} = {4'd2, 4'd1};
                6'b01????: {many_zeros, many_len} = {4'd1, 4'd2};
                default:   {many_zeros, many_len} = {4'd0, 4'd2};
            endcase
            4'd15: casez (many_window)
                6'b1?????: {many_zeros, many_len} = {4'd1, 4'd1};
                default:   {many_zeros, many_len} = {4'd0, 4'd1};
            endcase
            // counts below 4 belong to the other module
            default: {many_zeros, many_len} = {4'd0, 4'd0};
        endcase
    end

endmodule

// ==== design/tz_select_stage.sv ====
`timescale 1ns/100ps

module tz_select_stage
    import tz_bitstream_pkg::*, tz_result_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          s1_valid,
    input  logic          s1_chroma_dc,
    input  total_coeff_t  s1_total_coeff,
    input  total_zeros_t  cdc_zeros,
    input  code_len_t     cdc_len,
    input  total_zeros_t  few_zeros,
    input  code_len_t     few_len,
    input  total_zeros_t  many_zeros,
    input  code_len_t     many_len,
    output logic          out_valid,
    output total_zeros_t  total_zeros,
    output code_len_t     code_len
);

    total_zeros_t sel_zeros;
    code_len_t    sel_len;

    // table pick by request class
    always_comb begin
        if (s1_chroma_dc) begin
            sel_zeros = cdc_zeros;
            sel_len   = cdc_len;
        end else if (s1_total_coeff <= FEW_COEFF_MAX) begin
            sel_zeros = few_zeros;
            sel_len   = few_len;
        end else begin
            sel_zeros = many_zeros;
            sel_len   = many_len;
        end
    end

    // data held at zero between results
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            total_zeros <= '0;
            code_len    <= '0;
        end else begin
            out_valid   <= s1_valid;
            total_zeros <= s1_valid ? sel_zeros : '0;
            code_len    <= s1_valid ? sel_len : '0;
        end
    end

endmodule

// ==== design/tz_decoder_top.sv ====
`timescale 1ns/100ps
`include "tz_macros.svh"

module tz_decoder_top
    import tz_bitstream_pkg::*, tz_result_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  logic          chroma_dc,
    input  total_coeff_t  total_coeff,
    input  rbsp_window_t  rbsp,
    output logic          out_valid,
    output total_zeros_t  total_zeros,
    output code_len_t     code_len
);

    logic                      s1_valid;
    logic                      s1_chroma_dc;
    total_coeff_t              s1_total_coeff;
    logic [0:`TZ_CDC_BITS-1]   cdc_window;
    rbsp_window_t              few_window;
    logic [0:`TZ_MANY_BITS-1]  many_window;
    total_zeros_t              cdc_zeros;
    total_zeros_t              few_zeros;
    total_zeros_t              many_zeros;
    code_len_t                 cdc_len;
    code_len_t                 few_len;
    code_len_t                 many_len;

    // stage 1, request register and window routing
    tz_window_stage u_tz_window_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .chroma_dc      (chroma_dc),
        .total_coeff    (total_coeff),
        .rbsp           (rbsp),
        .s1_valid       (s1_valid),
        .s1_chroma_dc   (s1_chroma_dc),
        .s1_total_coeff (s1_total_coeff),
        .cdc_window     (cdc_window),
        .few_window     (few_window),
        .many_window    (many_window)
    );

    tz_lookup_few_coeffs u_tz_lookup_few_coeffs (
        .total_coeff (s1_total_coeff),
        .cdc_window  (cdc_window),
        .few_window  (few_window),
        .cdc_zeros   (cdc_zeros),
        .cdc_len     (cdc_len),
        .few_zeros   (few_zeros),
        .few_len     (few_len)
    );

    tz_lookup_many_coeffs u_tz_lookup_many_coeffs (
        .total_coeff (s1_total_coeff),
        .many_window (many_window),
        .many_zeros  (many_zeros),
        .many_len    (many_len)
    );

    // stage 2, result mux and output register
    tz_select_stage u_tz_select_stage (
        .clk            (clk),
        .rst_n          (rst_n),
        .s1_valid       (s1_valid),
        .s1_chroma_dc   (s1_chroma_dc),
        .s1_total_coeff (s1_total_coeff),
        .cdc_zeros      (cdc_zeros),
        .cdc_len        (cdc_len),
        .few_zeros      (few_zeros),
        .few_len        (few_len),
        .many_zeros     (many_zeros),
        .many_len       (many_len),
        .out_valid      (out_valid),
        .total_zeros    (total_zeros),
        .code_len       (code_len)
    );

endmodule

// ==== tb/tz_decoder_checker.sv ====
`timescale 1ns/100ps
`include "tz_macros.svh"

module tz_decoder_checker
    import tz_bitstream_pkg::*, tz_result_pkg::*;
(
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  logic          chroma_dc,
    input  total_coeff_t  total_coeff,
    input  logic          out_valid,
    input  total_zeros_t  total_zeros,
    input  code_len_t     code_len
);

    logic          vld_pipe [`TZ_LATENCY];
    logic          cdc_pipe [`TZ_LATENCY];
    total_coeff_t  tc_pipe  [`TZ_LATENCY];
    logic          req_cdc;
    total_coeff_t  req_tc;
    logic [4:0]    zeros_limit;
    code_len_t     len_limit;

    int reset_fails   = 0;
    int idle_fails    = 0;
    int latency_fails = 0;
    int range_fails   = 0;
    int zero_fails    = 0;
    int fail_count;

    // ----------------------------------------
    // request fields, delayed to line up with the result
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `TZ_LATENCY; i++) begin
                vld_pipe[i] <= 1'b0;
                cdc_pipe[i] <= 1'b0;
                tc_pipe[i]  <= '0;
            end
        end else begin
            vld_pipe[0] <= in_valid;
            cdc_pipe[0] <= chroma_dc;
            tc_pipe[0]  <= total_coeff;
            for (int i = 1; i < `TZ_LATENCY; i++) begin
                vld_pipe[i] <= vld_pipe[i-1];
                cdc_pipe[i] <= cdc_pipe[i-1];
                tc_pipe[i]  <= tc_pipe[i-1];
            end
        end
    end

    assign req_cdc = cdc_pipe[`TZ_LATENCY-1];
    assign req_tc  = tc_pipe[`TZ_LATENCY-1];

    // chroma DC 2x2 has at most 4 coefficients and 3-bit codes
    always_comb begin
        zeros_limit = 5'd16 - {1'b0, req_tc};
        len_limit   = 4'd9;
        if (req_cdc) begin
            zeros_limit = 5'd4 - {1'b0, req_tc};
            len_limit   = 4'd3;
        end
    end

    always_comb begin
        fail_count = reset_fails + idle_fails + latency_fails + range_fails + zero_fails;
    end

    // ----------------------------------------
    // assertions
    // ----------------------------------------
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !out_valid && total_zeros == '0 && code_len == '0)
        else begin
            reset_fails++;
            $error("outputs not cleared while in reset");
        end

    a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
        !out_valid |-> total_zeros == '0 && code_len == '0)
        else begin
            idle_fails++;
            $error("data outputs nonzero while out_valid is low");
        end

    // one result per request, exactly TZ_LATENCY edges later
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid == vld_pipe[`TZ_LATENCY-1])
        else begin
            latency_fails++;
            $error("out_valid does not follow in_valid by the pipeline latency");
        end

    a_range: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && req_tc != '0 |->
            {1'b0, total_zeros} <= zeros_limit && code_len >= 4'd1 && code_len <= len_limit)
        else begin
            range_fails++;
            $error("total_zeros %0d or code_len %0d out of range for TotalCoeff %0d",
                   total_zeros, code_len, req_tc);
        end

    a_zero_coeff: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && req_tc == '0 |-> total_zeros == '0 && code_len == '0)
        else begin
            zero_fails++;
            $error("nonzero result for TotalCoeff 0");
        end

endmodule

// ==== tb/tz_decoder_tb.sv ====
`timescale 1ns/100ps
`include "tz_macros.svh"

module tz_decoder_tb
    import tz_bitstream_pkg::*, tz_result_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int NUM_KNOWN    = 7;
    localparam int NUM_ZERO     = 4;
    localparam int NUM_RANDOM   = 160;
    // known codes go out twice and random requests may get one idle cycle each
    localparam int TIMEOUT_CYCLES =
        RESET_CYCLES + 2 * NUM_KNOWN + NUM_ZERO + 2 * NUM_RANDOM + 32;

    logic          clk;
    logic          rst_n;
    logic          in_valid;
    logic          chroma_dc;
    total_coeff_t  total_coeff;
    rbsp_window_t  rbsp;
    logic          out_valid;
    total_zeros_t  total_zeros;
    code_len_t     code_len;

    int seed        = 55;
    int cycle_count = 0;

    // results still in flight
    total_zeros_t  exp_zeros_q [$];
    code_len_t     exp_len_q   [$];
    logic          exp_check_q [$];
    logic          exp_pair_q  [$];
    total_zeros_t  exp_zeros;
    code_len_t     exp_len;
    logic          exp_check;
    logic          exp_pair;
    total_zeros_t  last_zeros;
    code_len_t     last_len;

    // ----------------------------------------
    // known codes from the standard tables
    // ----------------------------------------
    logic          known_cdc   [NUM_KNOWN] = '{1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
    total_coeff_t  known_tc    [NUM_KNOWN] = '{4'd1, 4'd1, 4'd3, 4'd1, 4'd4, 4'd13, 4'd15};
    rbsp_window_t  known_code  [NUM_KNOWN] = '{9'b100000000, 9'b000000000, 9'b000000000,
                                              9'b000000000, 9'b111000000, 9'b001000000,
                                              9'b100000000};
    total_zeros_t  known_zeros [NUM_KNOWN] = '{4'd0, 4'd15, 4'd1, 4'd3, 4'd1, 4'd1, 4'd1};
    code_len_t     known_len   [NUM_KNOWN] = '{4'd1, 4'd9, 4'd1, 4'd3, 4'd3, 4'd3, 4'd1};

    tz_decoder_top u_tz_decoder_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .chroma_dc   (chroma_dc),
        .total_coeff (total_coeff),
        .rbsp        (rbsp),
        .out_valid   (out_valid),
        .total_zeros (total_zeros),
        .code_len    (code_len)
    );

    bind tz_decoder_top tz_decoder_checker u_tz_decoder_checker (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .chroma_dc   (chroma_dc),
        .total_coeff (total_coeff),
        .out_valid   (out_valid),
        .total_zeros (total_zeros),
        .code_len    (code_len)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED at %0t: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run($sformatf("timeout, test still running after %0d cycles", TIMEOUT_CYCLES));
        end
    end

    function automatic int rand_range(input int lo, input int hi);
        int r;
        r = $random(seed);
        if (r < 0) begin
            r = -(r + 1);
        end
        return lo + r % (hi - lo + 1);
    endfunction

    function automatic rbsp_window_t random_window();
        logic [31:0] word;
        word = $random(seed);
        return word[`TZ_WINDOW_BITS-1:0];
    endfunction

    // code bits first then a random suffix
    function automatic rbsp_window_t window_with_code(input rbsp_window_t code,
                                                      input code_len_t len);
        rbsp_window_t win;
        win = random_window();
        for (int i = 0; i < `TZ_WINDOW_BITS; i++) begin
            if (i < int'(len)) begin
                win[i] = code[i];
            end
        end
        return win;
    endfunction

    task automatic send_request(input logic cdc, input total_coeff_t tc,
                                input rbsp_window_t win, input logic check,
                                input logic pair, input total_zeros_t zeros,
                                input code_len_t len);
        @(posedge clk);
        #1;
        in_valid    = 1'b1;
        chroma_dc   = cdc;
        total_coeff = tc;
        rbsp        = win;
        exp_zeros_q.push_back(zeros);
        exp_len_q.push_back(len);
        exp_check_q.push_back(check);
        exp_pair_q.push_back(pair);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        #1;
        in_valid    = 1'b0;
        chroma_dc   = 1'b0;
        total_coeff = '0;
        rbsp        = '0;
    endtask

    // ----------------------------------------
    // result monitor sampled mid-cycle
    // ----------------------------------------
    always @(negedge clk) begin
        if (u_tz_decoder_top.u_tz_decoder_checker.fail_count != 0) begin
            abort_run("an assertion in the bound checker failed");
        end else if (rst_n && out_valid) begin
            if (exp_check_q.size() == 0) begin
                abort_run("result appeared with no request pending");
            end else begin
                exp_zeros = exp_zeros_q.pop_front();
                exp_len   = exp_len_q.pop_front();
                exp_check = exp_check_q.pop_front();
                exp_pair  = exp_pair_q.pop_front();
                if (exp_check) begin
                    assert (total_zeros == exp_zeros && code_len == exp_len)
                        else report_mismatch($sformatf("got zeros %0d len %0d, expected %0d len %0d",
                                                       total_zeros, code_len, exp_zeros, exp_len));
                end
                // same code with a new suffix
                if (exp_pair) begin
                    assert (total_zeros == last_zeros && code_len == last_len)
                        else report_mismatch($sformatf("suffix changed result to zeros %0d len %0d",
                                                       total_zeros, code_len));
                end
                last_zeros = total_zeros;
                last_len   = code_len;
            end
        end
    end

    initial begin
        int   k;
        int   tc_int;
        logic cdc;
        in_valid    = 1'b0;
        chroma_dc   = 1'b0;
        total_coeff = '0;
        rbsp        = '0;
        rst_n       = 1'b0;
        last_zeros  = '0;
        last_len    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (k = 0; k < NUM_KNOWN; k++) begin
            send_request(known_cdc[k], known_tc[k], window_with_code(known_code[k], known_len[k]),
                         1'b1, 1'b0, known_zeros[k], known_len[k]);
            send_request(known_cdc[k], known_tc[k], window_with_code(known_code[k], known_len[k]),
                         1'b0, 1'b1, known_zeros[k], known_len[k]);
        end

        // no coefficients so nothing to read
        for (k = 0; k < NUM_ZERO; k++) begin
            send_request(k[0], 4'd0, random_window(), 1'b1, 1'b0, 4'd0, 4'd0);
        end

        // random traffic for the range assertions
        for (k = 0; k < NUM_RANDOM; k++) begin
            if (rand_range(0, 3) == 0) begin
                idle_cycle();
            end
            cdc = (rand_range(0, 1) == 1);
            if (cdc) begin
                tc_int = rand_range(1, 3);
            end else begin
                tc_int = rand_range(1, 15);
            end
            send_request(cdc, tc_int[3:0], random_window(), 1'b0, 1'b0, 4'd0, 4'd0);
        end
        idle_cycle();

        while (exp_check_q.size() != 0) begin
            @(posedge clk);
        end
        @(negedge clk);
        if (u_tz_decoder_top.u_tz_decoder_checker.fail_count != 0) begin
            abort_run("an assertion in the bound checker failed");
        end else begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== project.f ====
+incdir+include
design/tz_bitstream_pkg.sv
design/tz_result_pkg.sv
design/tz_window_stage.sv
design/tz_lookup_few_coeffs.sv
design/tz_lookup_many_coeffs.sv
design/tz_select_stage.sv
design/tz_decoder_top.sv
tb/tz_decoder_checker.sv
tb/tz_decoder_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build with Verilator, run, and take the verdict from the simulation log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tz_decoder_tb -f project.f \
    -o tz_decoder_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

# raised error limit lets the testbench print its own verdict after an assertion
./obj_dir/tz_decoder_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log

grep -q "TEST FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation passed"
